// File: Makefile
# Verilator build of the DBUS slice testbench

VERILATOR ?= verilator
TOP       ?= tbDbusSlice
FLAGS     ?= --binary --timing --assert -j 0
FILELIST  ?= dbusSlice.f
OBJDIR    ?= obj_dir
PASS_MSG  ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The run passes only when the pass message shows up as a line of its own
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: dataPath.sv
`timescale 1ns/100ps

module dataPath (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         enable,
   input  dbusPkg::aluOp_t              aluOp,
   input  logic [0:dbusPkg::wordWidth-1] dbus,
   output logic [0:dbusPkg::wordWidth-1] dp,
   output logic [0:dbusPkg::wordWidth-1] result
);
   import dbusPkg::*;

   //////////////////////////////
   // ALU
   //////////////////////////////

   // Old dp on one side, DBUS on the other
   // Add wraps at 2^36, carry out dropped
   always_comb
   begin
      case (aluOp)
         aluPass:
            result = dbus;
         aluAdd:
            result = dp + dbus;
         aluAnd:
            result = dp & dbus;
         aluXor:
            result = dp ^ dbus;
      endcase
   end

   //////////////////////////////
   // Datapath register
   //////////////////////////////

   // Loads once per enabled step
   // Holds otherwise
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         dp <= '0;
      else if (enable)
         dp <= result;
   end

endmodule

// File: dbmMux.sv
`timescale 1ns/100ps

module dbmMux (
   input  dbusPkg::dbmSel_t             sel,
   input  dbusPkg::numberField_u        number,
   input  logic [0:dbusPkg::wordWidth-1] memData,
   input  logic [0:dbusPkg::wordWidth-1] dp,
   output logic [0:dbusPkg::wordWidth-1] dbm
);
   import dbusPkg::*;

   // Halves of the datapath
   logic [0:halfWidth-1] dpLeft;
   logic [0:halfWidth-1] dpRight;

   // Bits 0..17 are the left half
   assign dpLeft  = dp[0:halfWidth-1];
   assign dpRight = dp[halfWidth:wordWidth-1];

   //////////////////////////////
   // DBM placement
   //////////////////////////////

   always_comb
   begin
      case (sel)
         // Constant in the right half
         dbmNumRight:
            dbm = {{halfWidth{1'b0}}, number.constant};
         // Constant in the left half
         dbmNumLeft:
            dbm = {number.constant, {halfWidth{1'b0}}};
         // Memory data straight through
         dbmMem:
            dbm = memData;
         // Halves of dp exchanged
         dbmDpSwap:
            dbm = {dpRight, dpLeft};
      endcase
   end

endmodule

// File: dbusMux.sv
`timescale 1ns/100ps

module dbusMux (
   input  dbusPkg::dbusSel_t            sel,
   input  logic                         forceRamfile,
   input  logic [0:dbusPkg::wordWidth-1] flags,
   input  logic [0:dbusPkg::wordWidth-1] dp,
   input  logic [0:dbusPkg::wordWidth-1] ram,
   input  logic [0:dbusPkg::wordWidth-1] dbm,
   output logic [0:dbusPkg::wordWidth-1] dbus
);
   import dbusPkg::*;

   // Select after the accumulator override
   dbusSel_t effSel;

   //////////////////////////////
   // Force ramfile
   //////////////////////////////

   // AC reference turns a DBM pick into the ramfile
   always_comb
   begin
      if (forceRamfile && (sel == dbusDbm))
         effSel = dbusRam;
      else
         effSel = sel;
   end

   //////////////////////////////
   // Source select
   //////////////////////////////

   always_comb
   begin
      case (effSel)
         dbusFlags: dbus = flags;
         dbusDp:    dbus = dp;
         dbusRam:   dbus = ram;
         dbusDbm:   dbus = dbm;
      endcase
   end

endmodule

// File: dbusPkg.sv
package dbusPkg;

   //////////////////////////////
   // Word sizes
   //////////////////////////////

   // Full 36-bit machine word
   localparam int wordWidth = 36;
   // Left and right halves
   localparam int halfWidth = wordWidth / 2;

   // Ramfile geometry
   localparam int ramDepth = 32;
   localparam int ramAddrWidth = $clog2(ramDepth);

   // Microword repeat field
   localparam int repeatWidth = 4;

   // Bits of the number field above the ramfile address
   localparam int sectionWidth = halfWidth - ramAddrWidth;

   //////////////////////////////
   // Microword encodings
   //////////////////////////////

   // DBUS source select
   typedef enum logic [0:1] {
      dbusFlags = 2'b00,
      dbusDp    = 2'b01,
      dbusRam   = 2'b10,
      dbusDbm   = 2'b11
   } dbusSel_t;

   // DBM source select
   typedef enum logic [0:1] {
      dbmNumRight = 2'b00,
      dbmNumLeft  = 2'b01,
      dbmMem      = 2'b10,
      dbmDpSwap   = 2'b11
   } dbmSel_t;

   // Two-bit ALU, old dp against DBUS
   typedef enum logic [0:1] {
      aluPass = 2'b00,
      aluAdd  = 2'b01,
      aluAnd  = 2'b10,
      aluXor  = 2'b11
   } aluOp_t;

   // Number field seen as a ramfile address
   // Section zero means an accumulator
   typedef struct packed {
      logic [0:sectionWidth-1] section;
      logic [0:ramAddrWidth-1] ramAddr;
   } ramAddrField_t;

   // Same 18 bits, constant or address
   typedef union packed {
      logic [0:halfWidth-1] constant;
      ramAddrField_t        addr;
   } numberField_u;

   // Microword, 31 bits, dbusSel is the MSB
   typedef struct packed {
      dbusSel_t             dbusSel;
      dbmSel_t              dbmSel;
      aluOp_t               aluOp;
      logic                 dpLoad;
      logic                 ramWrite;
      logic                 acRef;
      logic [0:repeatWidth-1] repeatCount;
      numberField_u         number;
   } cromWord_t;

   // Strobes from the sequencer to the datapath
   typedef struct packed {
      logic forceRamfile;
      logic dpEnable;
      logic ramEnable;
   } sliceStrobe_t;

endpackage

// File: dbusSlice.f
dbusPkg.sv
dbusMux.sv
dbmMux.sv
ramFile.sv
dataPath.sv
stepCounter.sv
microSeq.sv
dbusSlice.sv
tbClockGen.sv
tbDbusSlice.sv

// File: dbusSlice.sv
`timescale 1ns/100ps

module dbusSlice (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         start,
   input  dbusPkg::cromWord_t           crom,
   input  logic [0:dbusPkg::wordWidth-1] flags,
   input  logic [0:dbusPkg::wordWidth-1] memData,
   output logic [0:dbusPkg::wordWidth-1] dp,
   output logic [0:dbusPkg::wordWidth-1] dbus,
   output logic                         busy,
   output logic                         done
);
   import dbusPkg::*;

   //////////////////////////////
   // Internal nets
   //////////////////////////////

   // Latched microword and its strobes
   cromWord_t    curWord;
   sliceStrobe_t strobe;
   // Repeat counter handshake
   logic         load;
   logic         step;
   logic         lastStep;
   // Datapath sources
   logic [0:wordWidth-1] dbm;
   logic [0:wordWidth-1] ramData;
   // ALU output, also the ramfile write word
   logic [0:wordWidth-1] result;

   //////////////////////////////
   // Control
   //////////////////////////////

   microSeq i_microSeq (
      .clk      (clk),
      .rstN     (rstN),
      .start    (start),
      .crom     (crom),
      .lastStep (lastStep),
      .curWord  (curWord),
      .strobe   (strobe),
      .load     (load),
      .step     (step),
      .busy     (busy),
      .done     (done)
   );

   stepCounter i_stepCounter (
      .clk      (clk),
      .rstN     (rstN),
      .load     (load),
      .count    (crom.repeatCount),
      .step     (step),
      .lastStep (lastStep)
   );

   //////////////////////////////
   // Datapath
   //////////////////////////////

   dbmMux i_dbmMux (
      .sel     (curWord.dbmSel),
      .number  (curWord.number),
      .memData (memData),
      .dp      (dp),
      .dbm     (dbm)
   );

   dbusMux i_dbusMux (
      .sel          (curWord.dbusSel),
      .forceRamfile (strobe.forceRamfile),
      .flags        (flags),
      .dp           (dp),
      .ram          (ramData),
      .dbm          (dbm),
      .dbus         (dbus)
   );

   // Addressed by the low five bits of the number field
   ramFile i_ramFile (
      .clk       (clk),
      .rstN      (rstN),
      .addr      (curWord.number.addr.ramAddr),
      .writeEn   (strobe.ramEnable),
      .writeData (result),
      .readData  (ramData)
   );

   dataPath i_dataPath (
      .clk    (clk),
      .rstN   (rstN),
      .enable (strobe.dpEnable),
      .aluOp  (curWord.aluOp),
      .dbus   (dbus),
      .dp     (dp),
      .result (result)
   );

endmodule

// File: microSeq.sv
`timescale 1ns/100ps

module microSeq (
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  start,
   input  dbusPkg::cromWord_t    crom,
   input  logic                  lastStep,
   output dbusPkg::cromWord_t    curWord,
   output dbusPkg::sliceStrobe_t strobe,
   output logic                  load,
   output logic                  step,
   output logic                  busy,
   output logic                  done
);
   import dbusPkg::*;

   // Idle, executing, one-cycle done
   typedef enum logic [0:1] {
      stIdle,
      stRun,
      stFinish
   } seqState_t;

   seqState_t state;
   seqState_t stateNext;

   // Start seen while not executing
   logic accept;

   assign accept = start && !busy;
   assign load   = accept;

   //////////////////////////////
   // FSM
   //////////////////////////////

   always_comb
   begin
      stateNext = state;
      case (state)
         stIdle:
            if (accept)
               stateNext = stRun;
         stRun:
            if (lastStep)
               stateNext = stFinish;
         stFinish:
            // Back-to-back start allowed while done shows
            if (accept)
               stateNext = stRun;
            else
               stateNext = stIdle;
         default:
            stateNext = stIdle;
      endcase
   end

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         state <= stIdle;
      else
         state <= stateNext;
   end

   // Microword latch, only on an accepted start
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         curWord <= '0;
      else if (accept)
         curWord <= crom;
   end

   //////////////////////////////
   // Status and strobes
   //////////////////////////////

   assign busy = (state == stRun);
   assign done = (state == stFinish);
   // One execution step per run cycle
   assign step = busy;

   // AC reference with section zero picks an accumulator
   assign strobe.forceRamfile = curWord.acRef &&
                                (curWord.number.addr.section == {sectionWidth{1'b0}});
   assign strobe.dpEnable     = busy && curWord.dpLoad;
   assign strobe.ramEnable    = busy && curWord.ramWrite;

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Counter must hold the latched repeat when a run opens
   property pRunLength;
      @(posedge clk) disable iff (!rstN)
         $rose(busy) |-> (lastStep == (curWord.repeatCount == '0));
   endproperty

   aRunLength: assert property (pRunLength);

endmodule

// File: ramFile.sv
`timescale 1ns/100ps

module ramFile (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic [0:dbusPkg::ramAddrWidth-1] addr,
   input  logic                            writeEn,
   input  logic [0:dbusPkg::wordWidth-1]    writeData,
   output logic [0:dbusPkg::wordWidth-1]    readData
);
   import dbusPkg::*;

   //////////////////////////////
   // Storage
   //////////////////////////////

   // 32 words of 36 bits
   // Contents undefined after reset
   logic [0:wordWidth-1] mem [0:ramDepth-1];

   // Read port, same cycle
   assign readData = mem[addr];

   //////////////////////////////
   // Write port
   //////////////////////////////

   // Write lands at the closing edge of the step
   // Same-address read sees the new word next cycle
   always_ff @(posedge clk)
   begin
      if (writeEn)
         mem[addr] <= writeData;
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // ALU result must be clean whenever it is stored
   property pWriteKnown;
      @(posedge clk) disable iff (!rstN)
         writeEn |-> !$isunknown(writeData);
   endproperty

   aWriteKnown: assert property (pWriteKnown);

   // Address must be known too, else a random word is hit
   property pAddrKnown;
      @(posedge clk) disable iff (!rstN)
         writeEn |-> !$isunknown(addr);
   endproperty

   aAddrKnown: assert property (pAddrKnown);

endmodule

// File: stepCounter.sv
`timescale 1ns/100ps

module stepCounter (
   input  logic                           clk,
   input  logic                           rstN,
   input  logic                           load,
   input  logic [0:dbusPkg::repeatWidth-1] count,
   input  logic                           step,
   output logic                           lastStep
);
   import dbusPkg::*;

   // Steps left after the current one
   logic [0:repeatWidth-1] remaining;

   //////////////////////////////
   // Down-counter
   //////////////////////////////

   // Repeat field loaded on an accepted start
   // Stops at zero, never wraps
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         remaining <= '0;
      else if (load)
         remaining <= count;
      else if (step && !lastStep)
         remaining <= remaining - 1'b1;
   end

   // Zero left means this step is the final one
   assign lastStep = (remaining == '0);

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Sequencer must stop stepping once zero is reached
   property pNoStepPastZero;
      @(posedge clk) disable iff (!rstN)
         (step && lastStep) |=> (!step || load);
   endproperty

   aNoStepPastZero: assert property (pNoStepPastZero);

endmodule

// File: tbClockGen.sv
`timescale 1ns/100ps

module tbClockGen (
   output logic clk,
   output logic rstN
);

   // 8 ns period
   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;
   end

   // Reset held for 8 cycles, released just after an edge
   initial
   begin
      rstN = 1'b0;
      repeat (8) @(posedge clk);
      #1 rstN = 1'b1;
   end

endmodule

// File: tbDbusSlice.sv
`timescale 1ns/100ps

module tbDbusSlice;
   import dbusPkg::*;

   typedef logic [0:wordWidth-1] word_t;

   // At most 100 microwords, each up to 16 steps plus start, done and settle
   localparam int cycleLimit = 100 * ((1 << repeatWidth) + 4);

   logic      clk;
   logic      rstN;
   logic      start;
   cromWord_t crom;
   word_t     flags;
   word_t     memData;
   word_t     dp;
   word_t     dbus;
   logic      busy;
   logic      done;

   // Model of dp and ramfile
   word_t modelDp;
   word_t modelRam [0:ramDepth-1];

   int    cycleCount;
   int    checkCount;
   int    errorCount;
   int    testCount;
   int    testErrors;
   string testName;

   tbClockGen i_tbClockGen (
      .clk  (clk),
      .rstN (rstN)
   );

   dbusSlice i_dbusSlice (
      .clk     (clk),
      .rstN    (rstN),
      .start   (start),
      .crom    (crom),
      .flags   (flags),
      .memData (memData),
      .dp      (dp),
      .dbus    (dbus),
      .busy    (busy),
      .done    (done)
   );

   //////////////////////////////
   // Helpers
   //////////////////////////////

   // Drive and sample 1 ns after the edge
   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   function automatic word_t randWord();
      logic [63:0] r;
      r = {$urandom(), $urandom()};
      return r[wordWidth-1:0];
   endfunction

   function automatic logic [0:halfWidth-1] randHalf();
      logic [31:0] r;
      r = $urandom();
      return r[halfWidth-1:0];
   endfunction

   // Fill word built from every address bit
   function automatic word_t fillWord(int addr);
      logic [7:0] a;
      a = addr[7:0];
      return {4'hA, a, ~a, a * 8'd7, a ^ 8'h3C};
   endfunction

   // Number field as section plus ramfile address
   function automatic logic [0:halfWidth-1] numberFor(int section, int addr);
      ramAddrField_t f;
      f.section = section[sectionWidth-1:0];
      f.ramAddr = addr[ramAddrWidth-1:0];
      return f;
   endfunction

   function automatic cromWord_t makeWord(dbusSel_t dbusSel, dbmSel_t dbmSel, aluOp_t aluOp,
         logic dpLoad, logic ramWrite, logic acRef, int count, logic [0:halfWidth-1] number);
      cromWord_t w;
      w.dbusSel         = dbusSel;
      w.dbmSel          = dbmSel;
      w.aluOp           = aluOp;
      w.dpLoad          = dpLoad;
      w.ramWrite        = ramWrite;
      w.acRef           = acRef;
      w.repeatCount     = count[repeatWidth-1:0];
      w.number.constant = number;
      return w;
   endfunction

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic word_t modelAlu(aluOp_t op, word_t a, word_t b);
      case (op)
         aluAdd:  return a + b;
         aluAnd:  return a & b;
         aluXor:  return a ^ b;
         default: return b;
      endcase
   endfunction

   // Constant placed right or left, memory, or dp halves exchanged
   function automatic word_t modelDbm(cromWord_t w, word_t mem, word_t d);
      logic [0:halfWidth-1] c;
      c = w.number.constant;
      case (w.dbmSel)
         dbmNumRight: return {{halfWidth{1'b0}}, c};
         dbmNumLeft:  return {c, {halfWidth{1'b0}}};
         dbmMem:      return mem;
         default:     return {d[halfWidth:wordWidth-1], d[0:halfWidth-1]};
      endcase
   endfunction

   // All repeat+1 steps of one microword, DBUS of the last step returned
   task automatic modelRun(cromWord_t w, word_t f, word_t mem, output word_t lastDbus);
      int       addr;
      dbusSel_t sel;
      word_t    res;
      addr = int'(w.number.addr.ramAddr);
      sel  = w.dbusSel;
      // Accumulator reference turns DBM into the ramfile
      if (w.acRef && (w.number.addr.section == '0) && (sel == dbusDbm))
         sel = dbusRam;
      lastDbus = '0;
      for (int i = 0; i <= int'(w.repeatCount); i++)
      begin
         case (sel)
            dbusFlags: lastDbus = f;
            dbusDp:    lastDbus = modelDp;
            dbusRam:   lastDbus = modelRam[addr];
            default:   lastDbus = modelDbm(w, mem, modelDp);
         endcase
         res = modelAlu(w.aluOp, modelDp, lastDbus);
         if (w.ramWrite)
            modelRam[addr] = res;
         if (w.dpLoad)
            modelDp = res;
      end
   endtask

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic compareWord(string what, word_t expected, word_t actual);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("CHECK FAILED %s %s: expected %h, actual %h",
                  testName, what, expected, actual);
      end
   endtask

   task automatic compareBit(string what, logic expected, logic actual);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("CHECK FAILED %s %s: expected %b, actual %b",
                  testName, what, expected, actual);
      end
   endtask

   task automatic compareCount(string what, int expected, int actual);
      checkCount++;
      if (actual != expected)
      begin
         errorCount++;
         $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                  testName, what, expected, actual);
      end
   endtask

   task automatic beginTest(string name);
      testName   = name;
      testErrors = errorCount;
      testCount++;
   endtask

   task automatic endTest();
      if (errorCount == testErrors)
         $display("%s: ok", testName);
      else
         $display("%s: %0d errors", testName, errorCount - testErrors);
   endtask

   //////////////////////////////
   // Microword run
   //////////////////////////////

   // Optionally pulses a second start while the first word is busy
   task automatic runWord(cromWord_t w, word_t f, word_t mem, logic poke, cromWord_t pokeWord);
      word_t expDbus;
      word_t seenDbus;
      int    cycles;
      int    busyCycles;
      int    waitLimit;
      modelRun(w, f, mem, expDbus);
      crom     = w;
      flags    = f;
      memData  = mem;
      start    = 1'b1;
      seenDbus = '0;
      busyCycles = 0;
      waitLimit  = int'(w.repeatCount) + 8;
      nextCycle();
      cycles = 1;
      start  = 1'b0;
      if (poke)
      begin
         crom  = pokeWord;
         start = 1'b1;
      end
      while (!done && (cycles < waitLimit))
      begin
         if (busy)
         begin
            busyCycles++;
            seenDbus = dbus;
         end
         nextCycle();
         start = 1'b0;
         cycles++;
      end
      if (!done)
      begin
         errorCount++;
         $display("%s: done never came within %0d cycles", testName, cycles);
      end
      compareCount("done latency", int'(w.repeatCount) + 2, cycles);
      compareCount("busy cycles", int'(w.repeatCount) + 1, busyCycles);
      compareBit("busy with done", 1'b0, busy);
      compareWord("dbus on last step", expDbus, seenDbus);
      compareWord("dp", modelDp, dp);
      // Done is a single-cycle pulse
      nextCycle();
      compareBit("done after pulse", 1'b0, done);
   endtask

   //////////////////////////////
   // Directed tests
   //////////////////////////////

   // Memory data written through DBM into every word
   task automatic initRamfile();
      beginTest("ramfile fill");
      for (int a = 0; a < ramDepth; a++)
         runWord(makeWord(dbusDbm, dbmMem, aluPass, 1'b0, 1'b1, 1'b0, 0, numberFor(0, a)),
                 '0, fillWord(a), 1'b0, '0);
      endTest();
   endtask

   task automatic testDbusSources();
      word_t f;
      word_t m;
      int    a;
      beginTest("dbus sources");
      f = randWord();
      m = randWord();
      a = $urandom_range(0, ramDepth - 1);
      runWord(makeWord(dbusFlags, dbmMem, aluPass, 1'b1, 1'b0, 1'b0, 0, numberFor(1, a)),
              f, m, 1'b0, '0);
      runWord(makeWord(dbusDp, dbmMem, aluPass, 1'b1, 1'b0, 1'b0, 0, numberFor(1, a)),
              randWord(), m, 1'b0, '0);
      runWord(makeWord(dbusRam, dbmMem, aluPass, 1'b1, 1'b0, 1'b0, 0, numberFor(1, a)),
              f, m, 1'b0, '0);
      runWord(makeWord(dbusDbm, dbmMem, aluPass, 1'b1, 1'b0, 1'b0, 0, numberFor(1, a)),
              f, m, 1'b0, '0);
      endTest();
   endtask

   task automatic testDbmSelections();
      dbmSel_t s;
      beginTest("dbm selections");
      for (int i = 0; i < 4; i++)
      begin
         s = dbmSel_t'(i);
         runWord(makeWord(dbusDbm, s, aluPass, 1'b1, 1'b0, 1'b0, 0, randHalf()),
                 randWord(), randWord(), 1'b0, '0);
      end
      endTest();
   endtask

   task automatic testForceRamfile();
      word_t m;
      int    a;
      beginTest("force ramfile");
      m = randWord();
      a = $urandom_range(0, ramDepth - 1);
      // Section zero, ramfile word wins
      runWord(makeWord(dbusDbm, dbmMem, aluPass, 1'b1, 1'b0, 1'b1, 0, numberFor(0, a)),
              '0, m, 1'b0, '0);
      compareWord("forced word", fillWord(a), dp);
      // Nonzero section, DBM passes
      runWord(makeWord(dbusDbm, dbmMem, aluPass, 1'b1, 1'b0, 1'b1, 0, numberFor(77, a)),
              '0, m, 1'b0, '0);
      compareWord("unforced word", m, dp);
      runWord(makeWord(dbusDbm, dbmNumLeft, aluPass, 1'b1, 1'b0, 1'b1, 0, numberFor(0, a)),
              '0, m, 1'b0, '0);
      endTest();
   endtask

   task automatic testAluRepeat();
      logic [0:halfWidth-1] c;
      word_t sum;
      beginTest("alu and repeat");
      // All ones start so the add wraps
      runWord(makeWord(dbusDbm, dbmMem, aluPass, 1'b1, 1'b0, 1'b0, 0, '0),
              '0, '1, 1'b0, '0);
      sum = '1;
      c   = randHalf();
      for (int i = 0; i <= 5; i++)
         sum = sum + {{halfWidth{1'b0}}, c};
      runWord(makeWord(dbusDbm, dbmNumRight, aluAdd, 1'b1, 1'b0, 1'b0, 5, c),
              '0, '0, 1'b0, '0);
      compareWord("sum of 6 adds", sum, dp);
      for (int i = 0; i <= 15; i++)
         sum = sum + {{halfWidth{1'b0}}, c};
      runWord(makeWord(dbusDbm, dbmNumRight, aluAdd, 1'b1, 1'b0, 1'b0, 15, c),
              '0, '0, 1'b0, '0);
      compareWord("sum of 16 adds", sum, dp);
      runWord(makeWord(dbusDbm, dbmMem, aluAnd, 1'b1, 1'b0, 1'b0, 0, '0),
              '0, randWord(), 1'b0, '0);
      runWord(makeWord(dbusDbm, dbmMem, aluXor, 1'b1, 1'b0, 1'b0, 2, '0),
              '0, randWord(), 1'b0, '0);
      runWord(makeWord(dbusFlags, dbmMem, aluXor, 1'b1, 1'b0, 1'b0, 1, '0),
              randWord(), '0, 1'b0, '0);
      endTest();
   endtask

   task automatic testRamfileWrites();
      int a;
      int b;
      int c;
      beginTest("ramfile writes");
      a = $urandom_range(0, ramDepth - 1);
      b = (a + 7) % ramDepth;
      c = (a + 13) % ramDepth;
      runWord(makeWord(dbusDbm, dbmMem, aluXor, 1'b0, 1'b1, 1'b0, 0, numberFor(3, a)),
              '0, randWord(), 1'b0, '0);
      // Each step reads back the word it wrote the step before
      runWord(makeWord(dbusRam, dbmMem, aluAdd, 1'b1, 1'b1, 1'b0, 2, numberFor(5, b)),
              '0, '0, 1'b0, '0);
      runWord(makeWord(dbusRam, dbmMem, aluPass, 1'b1, 1'b0, 1'b0, 0, numberFor(9, a)),
              '0, '0, 1'b0, '0);
      runWord(makeWord(dbusRam, dbmMem, aluPass, 1'b1, 1'b0, 1'b0, 0, numberFor(9, b)),
              '0, '0, 1'b0, '0);
      // Untouched address keeps its fill
      runWord(makeWord(dbusRam, dbmMem, aluPass, 1'b1, 1'b0, 1'b0, 0, numberFor(9, c)),
              '0, '0, 1'b0, '0);
      compareWord("untouched word", fillWord(c), dp);
      endTest();
   endtask

   task automatic testStartWhileBusy();
      cromWord_t w;
      cromWord_t poke;
      beginTest("start while busy");
      w    = makeWord(dbusDbm, dbmNumRight, aluAdd, 1'b1, 1'b0, 1'b0, 7, randHalf());
      // Would load flags and write the ramfile if taken
      poke = makeWord(dbusFlags, dbmMem, aluPass, 1'b1, 1'b1, 1'b0, 3, numberFor(0, 9));
      runWord(w, randWord(), randWord(), 1'b1, poke);
      runWord(makeWord(dbusRam, dbmMem, aluPass, 1'b1, 1'b0, 1'b0, 0, numberFor(0, 9)),
              '0, '0, 1'b0, '0);
      endTest();
   endtask

   //////////////////////////////
   // Run control
   //////////////////////////////

   initial
   begin
      cycleCount = 0;
      while (cycleCount < cycleLimit)
      begin
         @(posedge clk);
         cycleCount++;
      end
      $display("Timeout: run still going after %0d cycles", cycleLimit);
      $display("Checks failed");
      $finish;
   end

   initial
   begin
      void'($urandom(70));
      start      = 1'b0;
      crom       = '0;
      flags      = '0;
      memData    = '0;
      modelDp    = '0;
      checkCount = 0;
      errorCount = 0;
      testCount  = 0;
      testErrors = 0;
      testName   = "";
      @(posedge rstN);
      nextCycle();
      initRamfile();
      testDbusSources();
      testDbmSelections();
      testForceRamfile();
      testAluRepeat();
      testRamfileWrites();
      testStartWhileBusy();
      $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
      if (errorCount == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule
